//--- Bender.yml
package:
  name: mm_trigger

sources:
  - include_dirs:
      - design
    files:
      - design/adc_sample_pkg.sv
      - design/trigger_pkg.sv
      - design/hit_detector.sv
      - design/sample_delay_line.sv
      - design/acquisition_controller.sv
      - design/mm_trigger_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/mm_trigger_tb.sv

//--- design/acquisition_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "mm_trigger_macros.svh"

module acquisition_controller import adc_sample_pkg::*, trigger_pkg::*; (
  input  wire              CLK,
  input  wire              RESET,
  input  wire              tvalid,
  input  wire              ready,
  input  wire pre_len_t    pre_len,
  input  wire adc_delta_t  threshold,
  input  wire adc_sample_t baseline,
  input  wire timestamp_t  current_time,
  input  wire              hit_echo,
  input  wire beat_t       aligned_beat,
  input  wire timestamp_t  aligned_time,
  input  wire              aligned_valid,
  output logic             armed,
  output adc_sample_t      cfg_baseline,
  output adc_delta_t       cfg_threshold,
  output logic             triggered,
  output timestamp_t       trigger_time,
  output record_t          dout,
  output logic             dout_valid
);

  pre_len_t    cfg_pre_len;
  pre_len_t    pre_last;
  pre_len_t    pre_count;
  logic        pre_done;
  logic        armed_d;
  logic        armed_q;
  logic        go;
  trig_state_e state;
  trig_state_e state_next;
  logic        trig_rise;
  post_count_t post_count;
  logic        post_done;
  adc_sample_t trig_baseline;

  // configuration follows the inputs while RESET is high
  always_ff @(posedge CLK) begin
    if (RESET) begin
      cfg_pre_len   <= pre_len;
      cfg_baseline  <= baseline;
      cfg_threshold <= threshold;
      trig_baseline <= baseline;
    end else if (trig_rise) begin
      trig_baseline <= cfg_baseline;
    end
  end

  // pre-fill: consecutive valid beats, any gap restarts it
  assign pre_last = cfg_pre_len - pre_len_t'(1);
  assign pre_done = (pre_count == pre_last);

  always_ff @(posedge CLK) begin
    if (RESET || !tvalid) begin
      pre_count <= '0;
    end else if (!pre_done) begin
      pre_count <= pre_count + pre_len_t'(1);
    end
  end

  assign armed_d = tvalid & ready & pre_done;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      armed_q <= 1'b0;
    end else begin
      armed_q <= armed_d;
    end
  end

  assign armed = armed_q;

  // trigger logic runs only while armed now and at the next edge
  assign go = armed_q & armed_d;
  assign post_done = (post_count == post_count_t'(`POST_LEN - 1));

  always_comb begin
    state_next = state;
    if (!go) begin
      state_next = FILLING;
    end else if (hit_echo) begin
      state_next = TRIGGERED;
    end else begin
      case (state)
        FILLING: begin
          state_next = ARMED;
        end
        ARMED: begin
          state_next = ARMED;
        end
        TRIGGERED: begin
          if (post_done) begin
            state_next = ARMED;
          end
        end
        default: begin
          state_next = FILLING;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state <= FILLING;
    end else begin
      state <= state_next;
    end
  end

  assign triggered = (state == TRIGGERED);
  assign trig_rise = (state_next == TRIGGERED) && (state != TRIGGERED);

  // post counter restarts on every echo cycle
  always_ff @(posedge CLK) begin
    if (RESET || !go || hit_echo) begin
      post_count <= '0;
    end else if (state == TRIGGERED && !post_done) begin
      post_count <= post_count + post_count_t'(1);
    end else begin
      post_count <= '0;
    end
  end

  // time stamp points back to the start of the pre-fill
  always_ff @(posedge CLK) begin
    if (RESET) begin
      trigger_time <= '0;
    end else if (trig_rise) begin
      trigger_time <= current_time - cfg_pre_len;
    end
  end

  // record goes out with the aligned data, no extra stage
  assign dout       = {aligned_beat, aligned_time, trig_baseline, cfg_threshold};
  assign dout_valid = aligned_valid;

  a_trig_needs_armed : assert property (
    @(posedge CLK) disable iff (RESET)
    triggered |-> armed_q
  );

endmodule

`default_nettype wire

//--- design/adc_sample_pkg.sv
`default_nettype none

`include "mm_trigger_macros.svh"

package adc_sample_pkg;

  // raw sample, also used for the baseline
  typedef logic signed [`ADC_BITS-1:0] adc_sample_t;

  // baseline-corrected value, one bit wider
  typedef logic signed [`ADC_BITS:0] adc_delta_t;

  // sign-extended word as it leaves the data path
  typedef logic [`WORD_BITS-1:0] sample_word_t;

  // full stream beat
  typedef logic [`SAMPLES_PER_BEAT*`WORD_BITS-1:0] beat_t;

endpackage

`default_nettype wire

//--- design/hit_detector.sv
`timescale 1ns/100ps
`default_nettype none

`include "mm_trigger_macros.svh"

module hit_detector import adc_sample_pkg::*; (
  input  wire              CLK,
  input  wire              RESET,
  input  wire beat_t       tdata,
  input  wire              tvalid,
  input  wire              armed,
  input  wire adc_sample_t cfg_baseline,
  input  wire adc_delta_t  cfg_threshold,
  output logic             hit_echo
);

  localparam int NUM_WINDOWS = `SAMPLES_PER_BEAT / `HIT_WINDOW;

  logic [`SAMPLES_PER_BEAT-1:0] compare_d;
  logic [`SAMPLES_PER_BEAT-1:0] compare_q;
  logic [NUM_WINDOWS-1:0]       window_hit;
  logic                         hit;
  logic                         hit_dly;

  // per sample: top-aligned 12 bits minus baseline, then threshold compare
  for (genvar i = 0; i < `SAMPLES_PER_BEAT; i++) begin : g_sample
    adc_sample_t sample;
    adc_delta_t  delta;

    assign sample = tdata[`WORD_BITS*(i+1)-1 -: `ADC_BITS];
    // signed, widened to 13 bits before the subtraction
    assign delta = sample - cfg_baseline;
    assign compare_d[i] = (delta >= cfg_threshold);
  end

  // every sample of an aligned window must reach the threshold
  for (genvar w = 0; w < NUM_WINDOWS; w++) begin : g_window
    assign window_hit[w] = &compare_q[`HIT_WINDOW*w +: `HIT_WINDOW];
  end

  // compare stage, empty for invalid beats
  always_ff @(posedge CLK) begin
    if (RESET || !tvalid || !armed) begin
      compare_q <= '0;
    end else begin
      compare_q <= compare_d;
    end
  end

  // hit stage plus one delayed copy for the stretch
  always_ff @(posedge CLK) begin
    if (RESET || !armed) begin
      hit     <= 1'b0;
      hit_dly <= 1'b0;
    end else begin
      hit     <= |window_hit;
      hit_dly <= hit;
    end
  end

  // two cycle wide echo
  assign hit_echo = hit | hit_dly;

  // a hit always traces back to a valid beat two cycles earlier
  a_hit_needs_valid : assert property (
    @(posedge CLK) disable iff (RESET)
    $rose(hit_echo) |-> $past(tvalid, 2)
  );

endmodule

`default_nettype wire

//--- design/mm_trigger_macros.svh
`ifndef MM_TRIGGER_MACROS_SVH
`define MM_TRIGGER_MACROS_SVH

// ADC sample resolution
`define ADC_BITS 12
// words per stream beat and their container width
`define SAMPLES_PER_BEAT 16
`define WORD_BITS 16
// samples per aligned detection window
`define HIT_WINDOW 8
// beats kept after the last hit
`define POST_LEN 38
`define TS_BITS 48
`define PRE_LEN_BITS 5
// data path latency in beats
`define ALIGN_DELAY 3

`endif

//--- design/mm_trigger_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mm_trigger_macros.svh"

module mm_trigger_top import adc_sample_pkg::*, trigger_pkg::*; (
  input  wire              CLK,
  input  wire              RESET,
  input  wire beat_t       tdata,
  input  wire              tvalid,
  input  wire              ready,
  input  wire pre_len_t    pre_len,
  input  wire adc_delta_t  threshold,
  input  wire adc_sample_t baseline,
  input  wire timestamp_t  current_time,
  output logic             triggered,
  output timestamp_t       trigger_time,
  output record_t          dout,
  output logic             dout_valid
);

  adc_sample_t cfg_baseline;
  adc_delta_t  cfg_threshold;
  logic        armed;
  logic        hit_echo;
  beat_t       aligned_beat;
  timestamp_t  aligned_time;
  logic        aligned_valid;

  hit_detector u_hit_detector (
    .CLK           (CLK),
    .RESET         (RESET),
    .tdata         (tdata),
    .tvalid        (tvalid),
    .armed         (armed),
    .cfg_baseline  (cfg_baseline),
    .cfg_threshold (cfg_threshold),
    .hit_echo      (hit_echo)
  );

  sample_delay_line u_sample_delay_line (
    .CLK           (CLK),
    .RESET         (RESET),
    .tdata         (tdata),
    .tvalid        (tvalid),
    .current_time  (current_time),
    .aligned_beat  (aligned_beat),
    .aligned_time  (aligned_time),
    .aligned_valid (aligned_valid)
  );

  // combines the hit decision with the realigned data
  acquisition_controller u_acquisition_controller (
    .CLK           (CLK),
    .RESET         (RESET),
    .tvalid        (tvalid),
    .ready         (ready),
    .pre_len       (pre_len),
    .threshold     (threshold),
    .baseline      (baseline),
    .current_time  (current_time),
    .hit_echo      (hit_echo),
    .aligned_beat  (aligned_beat),
    .aligned_time  (aligned_time),
    .aligned_valid (aligned_valid),
    .armed         (armed),
    .cfg_baseline  (cfg_baseline),
    .cfg_threshold (cfg_threshold),
    .triggered     (triggered),
    .trigger_time  (trigger_time),
    .dout          (dout),
    .dout_valid    (dout_valid)
  );

  // output strobe is never stalled by ready
  a_dout_latency : assert property (
    @(posedge CLK) disable iff (RESET)
    (!$past(RESET, 1) && !$past(RESET, 2) && !$past(RESET, `ALIGN_DELAY))
      |-> (dout_valid == $past(tvalid, `ALIGN_DELAY))
  );

endmodule

`default_nettype wire

//--- design/sample_delay_line.sv
`timescale 1ns/100ps
`default_nettype none

`include "mm_trigger_macros.svh"

module sample_delay_line import adc_sample_pkg::*, trigger_pkg::*; (
  input  wire             CLK,
  input  wire             RESET,
  input  wire beat_t      tdata,
  input  wire             tvalid,
  input  wire timestamp_t current_time,
  output beat_t           aligned_beat,
  output timestamp_t      aligned_time,
  output logic            aligned_valid
);

  beat_t      beat_s1;
  beat_t      beat_s2;
  beat_t      beat_s3;
  beat_t      beat_ext;
  timestamp_t time_s1;
  timestamp_t time_s2;
  timestamp_t time_s3;
  logic       valid_s1;
  logic       valid_s2;
  logic       valid_s3;

  // each word becomes the sign extension of its 12-bit sample
  for (genvar i = 0; i < `SAMPLES_PER_BEAT; i++) begin : g_extend
    adc_sample_t  sample;
    sample_word_t word_ext;

    assign sample = beat_s1[`WORD_BITS*(i+1)-1 -: `ADC_BITS];
    assign word_ext = {{(`WORD_BITS-`ADC_BITS){sample[`ADC_BITS-1]}}, sample};
    assign beat_ext[`WORD_BITS*i +: `WORD_BITS] = word_ext;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
      valid_s3 <= 1'b0;
      beat_s1  <= '1;
      beat_s2  <= '1;
      beat_s3  <= '1;
    end else begin
      valid_s1 <= tvalid;
      valid_s2 <= valid_s1;
      valid_s3 <= valid_s2;
      beat_s1  <= tdata;
      beat_s2  <= beat_ext;
      beat_s3  <= beat_s2;
    end
  end

  // time stamps ride along
  always_ff @(posedge CLK) begin
    time_s1 <= current_time;
    time_s2 <= time_s1;
    time_s3 <= time_s2;
  end

  assign aligned_beat  = beat_s3;
  assign aligned_time  = time_s3;
  assign aligned_valid = valid_s3;

  a_valid_latency : assert property (
    @(posedge CLK) disable iff (RESET)
    (!$past(RESET, 1) && !$past(RESET, 2) && !$past(RESET, 3))
      |-> (aligned_valid == $past(tvalid, 3))
  );

endmodule

`default_nettype wire

//--- design/trigger_pkg.sv
`default_nettype none

`include "mm_trigger_macros.svh"

package trigger_pkg;

  typedef logic [`TS_BITS-1:0] timestamp_t;

  typedef logic [`PRE_LEN_BITS-1:0] pre_len_t;

  typedef logic [$clog2(`POST_LEN)-1:0] post_count_t;

  // beat, time, baseline at trigger, threshold
  typedef logic [`SAMPLES_PER_BEAT*`WORD_BITS+`TS_BITS+2*`ADC_BITS:0] record_t;

  typedef enum logic [1:0] {
    FILLING,
    ARMED,
    TRIGGERED
  } trig_state_e;

endpackage

`default_nettype wire

//--- mm_trigger_top.f
+incdir+design
design/adc_sample_pkg.sv
design/trigger_pkg.sv
design/hit_detector.sv
design/sample_delay_line.sv
design/acquisition_controller.sv
design/mm_trigger_top.sv
tests/mm_trigger_tb.sv

//--- tests/mm_trigger_stim.txt
# cfg  id pre_len threshold baseline
# beat id tvalid ready fill hit_start hit_count hit_value repeat expected_triggered
cfg 1 4 100 0
beat 1 1 1 0 0 0 0 2 0
beat 1 1 1 0 0 8 200 1 0
beat 1 1 1 0 0 0 0 3 0
beat 1 1 1 0 0 8 200 1 0
beat 1 1 1 0 0 0 0 1 0
beat 1 1 1 0 0 0 0 39 1
beat 1 1 1 0 0 0 0 3 0
cfg 2 6 50 -300
beat 2 1 1 -1000 0 0 0 4 0
beat 2 0 1 -1000 0 0 0 1 0
beat 2 1 1 -1000 0 0 0 3 0
beat 2 1 1 -1000 0 16 -200 1 0
beat 2 1 1 -1000 0 0 0 2 0
beat 2 1 1 -1000 8 8 -200 1 0
beat 2 1 1 -1000 0 0 0 1 0
beat 2 1 1 -1000 0 0 0 17 1
beat 2 1 1 -1000 0 8 -200 1 1
beat 2 1 1 -1000 0 0 0 40 1
beat 2 1 1 -1000 0 0 0 2 0
cfg 3 2 10 5
beat 3 1 1 0 0 0 0 2 0
beat 3 1 1 0 0 7 20 1 0
beat 3 1 1 0 0 0 0 1 0
beat 3 1 1 0 4 8 20 1 0
beat 3 1 1 0 0 0 0 1 0
beat 3 1 1 0 8 8 20 1 0
beat 3 1 1 0 0 0 0 1 0
beat 3 1 1 0 0 0 0 39 1
beat 3 1 1 0 0 0 0 1 0
cfg 4 2 10 0
beat 4 1 1 0 0 0 0 3 0
beat 4 1 1 0 0 8 100 1 0
beat 4 1 1 0 0 0 0 1 0
beat 4 1 1 0 0 0 0 5 1
beat 4 1 0 0 0 0 0 2 0
beat 4 1 0 0 8 8 100 1 0
beat 4 1 0 0 0 0 0 1 0
beat 4 1 1 0 0 0 0 3 0

//--- tests/mm_trigger_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mm_trigger_macros.svh"

module mm_trigger_tb import adc_sample_pkg::*, trigger_pkg::*; ();

  localparam int MAX_LINES = 64;

  logic        CLK;
  logic        RESET;
  beat_t       tdata;
  logic        tvalid;
  logic        ready;
  pre_len_t    pre_len;
  adc_delta_t  threshold;
  adc_sample_t baseline;
  timestamp_t  current_time;
  logic        triggered;
  timestamp_t  trigger_time;
  record_t     dout;
  logic        dout_valid;

  // parsed stimulus, one row per file line
  int          fld [MAX_LINES][9];
  bit          is_cfg [MAX_LINES];
  int          num_lines;
  logic [31:0] lfsr_state;
  timestamp_t  cycle_count = '0;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  string       test_name;
  longint      watchdog_ns;
  logic        prev_expected;
  beat_t       hist_beat [$];
  timestamp_t  hist_time [$];
  logic        hist_valid [$];

  mm_trigger_top UUT (
    .CLK          (CLK),
    .RESET        (RESET),
    .tdata        (tdata),
    .tvalid       (tvalid),
    .ready        (ready),
    .pre_len      (pre_len),
    .threshold    (threshold),
    .baseline     (baseline),
    .current_time (current_time),
    .triggered    (triggered),
    .trigger_time (trigger_time),
    .dout         (dout),
    .dout_valid   (dout_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  // galois lfsr, one step per bit taken
  function automatic logic next_lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    return b;
  endfunction

  // raw beat for the DUT and the sign-extended beat expected at dout
  task automatic build_beat(input int fill, input int hs, input int hc, input int hv,
                            output beat_t raw, output beat_t ext);
    adc_sample_t s;
    logic [3:0]  low;
    for (int i = 0; i < `SAMPLES_PER_BEAT; i++) begin
      s = (i >= hs && i < hs + hc) ? adc_sample_t'(hv) : adc_sample_t'(fill);
      for (int b = 0; b < 4; b++) begin
        low[b] = next_lfsr_bit();
      end
      raw[`WORD_BITS*i +: `WORD_BITS] = {s, low};
      ext[`WORD_BITS*i +: `WORD_BITS] = {{(`WORD_BITS-`ADC_BITS){s[`ADC_BITS-1]}}, s};
    end
  endtask

  task automatic check_beat(input string what, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_time(input string what, input timestamp_t exp, input timestamp_t act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_level(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_record(input string what, input record_t exp, input record_t act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic read_stim();
    int    fd;
    int    n;
    string line;
    string kind;
    int    a [9];
    num_lines = 0;
    fd = $fopen("tests/mm_trigger_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
    end else begin
      while (!$feof(fd) && num_lines < MAX_LINES) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 2 && line[0] != "#") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d", kind,
                      a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8]);
          is_cfg[num_lines] = (kind == "cfg");
          for (int c = 0; c < 9; c++) begin
            fld[num_lines][c] = a[c];
          end
          num_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  // config is applied while RESET is high for 10 cycles
  task automatic start_test(input int id, input int pl, input int thr, input int base);
    test_name = $sformatf("test%0d", id);
    test_errors = 0;
    tests_run++;
    prev_expected = 1'b0;
    hist_beat.delete();
    hist_time.delete();
    hist_valid.delete();
    RESET = 1'b1;
    tvalid = 1'b0;
    ready = 1'b0;
    pre_len = pre_len_t'(pl);
    threshold = adc_delta_t'(thr);
    baseline = adc_sample_t'(base);
    repeat (10) begin
      @(posedge CLK);
      #2;
    end
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("%s ok", test_name);
    end else begin
      $display("%s failed with %0d errors", test_name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
  endtask

  task automatic run_segment(input int v, input int r, input int fill, input int hs,
                             input int hc, input int hv, input int rep, input int exp);
    beat_t   raw;
    beat_t   ext;
    record_t exp_rec;
    int      j;
    int      k;
    repeat (rep) begin
      build_beat(fill, hs, hc, hv, raw, ext);
      RESET = 1'b0;
      tvalid = v[0];
      ready = r[0];
      tdata = raw;
      current_time = cycle_count;
      hist_beat.push_back(ext);
      hist_time.push_back(cycle_count);
      hist_valid.push_back(v[0]);
      @(posedge CLK);
      #1;
      j = hist_beat.size() - 1;
      check_level("triggered", exp[0], triggered);
      // time stamp taken on the edge where triggered rises
      if (exp[0] && !prev_expected) begin
        check_time("trigger_time", hist_time[j] - timestamp_t'(pre_len), trigger_time);
      end
      prev_expected = exp[0];
      // three registers, so dout shows the beat captured two edges earlier
      if (j >= `ALIGN_DELAY - 1) begin
        k = j - (`ALIGN_DELAY - 1);
        check_level("dout_valid", hist_valid[k], dout_valid);
        check_beat("dout beat", hist_beat[k], dout[$bits(record_t)-1 -: $bits(beat_t)]);
        exp_rec = {hist_beat[k], hist_time[k], baseline, threshold};
        check_record("dout record", exp_rec, dout);
      end
      #1;
    end
  endtask

  initial begin
    longint total;
    RESET = 1'b1;
    tdata = '0;
    tvalid = 1'b0;
    ready = 1'b0;
    pre_len = '0;
    threshold = '0;
    baseline = '0;
    current_time = '0;
    lfsr_state = 32'h7185;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_name = "none";
    prev_expected = 1'b0;
    watchdog_ns = 0;
    read_stim();
    total = 0;
    for (int i = 0; i < num_lines; i++) begin
      total += is_cfg[i] ? 10 : fld[i][7];
    end
    watchdog_ns = 2 * (total + 2) * 20;
    @(posedge CLK);
    #2;
    for (int i = 0; i < num_lines; i++) begin
      if (is_cfg[i]) begin
        if (tests_run > 0) begin
          finish_test();
        end
        start_test(fld[i][0], fld[i][1], fld[i][2], fld[i][3]);
      end else begin
        run_segment(fld[i][1], fld[i][2], fld[i][3], fld[i][4], fld[i][5], fld[i][6],
                    fld[i][7], fld[i][8]);
      end
    end
    if (tests_run > 0) begin
      finish_test();
    end
    $display("%0d tests run, %0d failed, %0d errors in total", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // run length follows from the stimulus file
  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("watchdog expired before all stimulus lines were run");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
